//--- rtl/mem_pkg.sv
/*
 * mem_pkg: widths and the request struct shared by the slow memory subsystem
 */

`default_nettype none

package mem_pkg;

  localparam int unsigned MemDataWidth = 32;
  localparam int unsigned MemBeWidth   = MemDataWidth / 8;   // one enable per byte lane
  localparam int unsigned MemAddrWidth = 16;                 // word address, memory decodes low bits
  localparam int unsigned WaitCntWidth = 6;                  // latency counts 1 to 32

  // request as seen on the port, in the capture register and at the sram
  typedef struct packed {
    logic                    we;     // 1 = write, 0 = read
    logic [MemAddrWidth-1:0] addr;
    logic [MemDataWidth-1:0] wdata;
    logic [MemBeWidth-1:0]   be;     // only used on writes
  } mem_req_t;

endpackage : mem_pkg

`default_nettype wire

//--- rtl/latency_lfsr.sv
/*
 * latency_lfsr: 16-bit Galois LFSR giving the grant decision bit
 * and the random wait value for the slow memory controller
 */

`default_nettype none

module latency_lfsr #(
  parameter logic [15:0] Seed = 16'hace1
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  output logic       grant_ok_o,
  output logic [4:0] wait_rnd_o
);

  // x^16 + x^14 + x^13 + x^11 + 1, maximal length
  localparam logic [15:0] Taps = 16'hb400;

  // an all-zero state would lock the register up
  localparam logic [15:0] SafeSeed = (Seed == 16'h0000) ? 16'h0001 : Seed;

  logic [15:0] lfsr_q;
  logic [15:0] lfsr_d;

  always_comb begin
    lfsr_d = {1'b0, lfsr_q[15:1]};
    if (lfsr_q[0]) begin
      lfsr_d = lfsr_d ^ Taps;  // feed back the shifted-out bit
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= SafeSeed;
    end else begin
      lfsr_q <= lfsr_d;  // steps every cycle, busy or not
    end
  end

  // grant and latency come from disjoint bits
  assign grant_ok_o = lfsr_q[15];
  assign wait_rnd_o = lfsr_q[4:0];

endmodule : latency_lfsr

`default_nettype wire

//--- rtl/sram_1rw.sv
/*
 * sram_1rw: single-port word memory, byte-enabled write,
 * registered read data
 */

`default_nettype none

module sram_1rw import mem_pkg::*; #(
  parameter int unsigned NumWords = 256
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  mem_req_t                cmd_i,
  output logic [MemDataWidth-1:0] rdata_o
);

  localparam int unsigned IdxWidth = (NumWords > 1) ? $clog2(NumWords) : 1;

  // storage split into byte lanes so the enables map straight onto it
  logic [MemBeWidth-1:0][7:0] mem_q [NumWords];

  logic [IdxWidth-1:0]     idx;
  logic                    wr_en;
  logic                    rd_en;
  logic [MemDataWidth-1:0] rdata_q;

  assign idx   = cmd_i.addr[IdxWidth-1:0];  // upper address bits ignored
  assign wr_en = req_i & cmd_i.we;
  assign rd_en = req_i & ~cmd_i.we;

  // write port
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < MemBeWidth; b++) begin
        if (cmd_i.be[b]) begin
          mem_q[idx][b] <= cmd_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read port, data lands one cycle after the strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= mem_q[idx];
    end
  end

  // holds last read word across writes
  assign rdata_o = rdata_q;

endmodule : sram_1rw

`default_nettype wire

//--- rtl/slow_mem_ctrl.sv
/*
 * slow_mem_ctrl: ready/wait FSM that grants one request at a time,
 * holds it for a random latency, then fires a single memory access
 */

`default_nettype none

module slow_mem_ctrl import mem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // requester side
  input  logic       req_i,
  input  mem_req_t   mem_req_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  // randomness
  input  logic       grant_ok_i,
  input  logic [4:0] wait_rnd_i,
  // memory side
  output logic       ram_req_o,
  output mem_req_t   ram_cmd_o
);

  typedef enum logic {
    READY,
    WAIT
  } state_e;

  state_e state_q;
  state_e state_d;

  logic [WaitCntWidth-1:0] cnt_q;
  logic [WaitCntWidth-1:0] cnt_d;
  logic [WaitCntWidth-1:0] cnt_load;

  mem_req_t cmd_q;

  logic rvalid_q;
  logic gnt;
  logic fire;

  // wait value of 0..31 becomes a count of 1..32
  assign cnt_load = WaitCntWidth'(wait_rnd_i) + WaitCntWidth'(1);

  // grant only when idle and the lfsr says yes
  assign gnt = (state_q == READY) & req_i & grant_ok_i;

  // last cycle of the wait, access goes out now
  assign fire = (state_q == WAIT) && (cnt_q == WaitCntWidth'(1));

  // next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      READY: begin
        if (gnt) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (fire) begin
          state_d = READY;
        end
      end
      default: begin
        state_d = READY;
      end
    endcase
  end

  // latency counter
  always_comb begin
    cnt_d = cnt_q;
    if (gnt) begin
      cnt_d = cnt_load;
    end else if (state_q == WAIT && !fire) begin
      cnt_d = cnt_q - WaitCntWidth'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= READY;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // capture the request on its grant, held until the access
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      cmd_q <= mem_req_i;
    end
  end

  // response flag trails the access by one cycle, matching sram read data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= fire;  // also pulses for writes
    end
  end

  assign gnt_o     = gnt;
  assign rvalid_o  = rvalid_q;
  assign ram_req_o = fire;
  assign ram_cmd_o = cmd_q;

endmodule : slow_mem_ctrl

`default_nettype wire

//--- rtl/mem_subsys.sv
/*
 * mem_subsys: slow memory top, ties the controller, the latency LFSR
 * and the single-port SRAM together
 */

`default_nettype none

module mem_subsys import mem_pkg::*; #(
  parameter int unsigned NumWords = 256,
  parameter logic [15:0] LfsrSeed = 16'hace1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  mem_req_t                mem_req_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output logic [MemDataWidth-1:0] rdata_o
);

  logic       grant_ok;
  logic [4:0] wait_rnd;
  logic       ram_req;   // one-cycle access strobe
  mem_req_t   ram_cmd;   // captured request

  latency_lfsr #(
    .Seed (LfsrSeed)
  ) u_latency_lfsr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .grant_ok_o (grant_ok),
    .wait_rnd_o (wait_rnd)
  );

  slow_mem_ctrl u_slow_mem_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .mem_req_i  (mem_req_i),
    .gnt_o      (gnt_o),
    .rvalid_o   (rvalid_o),
    .grant_ok_i (grant_ok),
    .wait_rnd_i (wait_rnd),
    .ram_req_o  (ram_req),
    .ram_cmd_o  (ram_cmd)
  );

  sram_1rw #(
    .NumWords (NumWords)
  ) u_sram_1rw (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (ram_req),
    .cmd_i   (ram_cmd),
    .rdata_o (rdata_o)   // read data goes straight out
  );

endmodule : mem_subsys

`default_nettype wire

//--- test/tb_clk_gen.sv
/*
 * tb_clk_gen: 100 ns clock and a reset held low for the first cycles
 */

`default_nettype none

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #50ns clk_o = ~clk_o;  // 100 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #10ns;
    rst_no = 1'b1;  // released clear of the edge
  end

endmodule : tb_clk_gen

`default_nettype wire

//--- test/mem_subsys_sva.sv
/*
 * mem_subsys_sva: request/grant/response protocol checks on the slow memory top
 */

`default_nettype none

module mem_subsys_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic       busy_q;  // granted, response not seen yet
  logic [6:0] lat_q;   // cycles since that grant

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      lat_q  <= '0;
    end else if (gnt_i) begin
      busy_q <= 1'b1;  // a grant may share the cycle with the old response
      lat_q  <= 7'd1;
    end else if (rvalid_i) begin
      busy_q <= 1'b0;
    end else if (busy_q && lat_q != 7'h7f) begin
      lat_q <= lat_q + 7'd1;
    end
  end

  a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> req_i)
    else $error("grant seen while no request is raised");

  a_one_outstanding : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> (!busy_q || rvalid_i))
    else $error("second grant while a request is still outstanding");

  a_rvalid_has_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> busy_q)
    else $error("response without a granted request");

  a_rvalid_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> (lat_q >= 7'd2 && lat_q <= 7'd33))
    else $error("response outside 2 to 33 cycles after its grant");

  a_rvalid_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |=> !rvalid_i)
    else $error("response held for more than one cycle");

  a_no_hang : assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q |-> lat_q <= 7'd33)
    else $error("granted request never answered");

endmodule : mem_subsys_sva

`default_nettype wire

//--- test/tb_mem_subsys.sv
/*
 * tb_mem_subsys: table-driven test of the slow memory, with a shadow
 * memory model, per-row reporting and a watchdog
 */

`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumWords    = 256;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned IdleCycles  = 8;
  localparam int unsigned NumDirected = 14;
  localparam int unsigned NumTail     = 22;
  localparam int unsigned NumRows     = NumDirected + NumTail;
  localparam int unsigned GntTimeout  = 64;
  localparam int unsigned RspTimeout  = 40;  // beyond the 33 cycle worst case
  localparam int unsigned WatchdogCycles = NumRows * 40 + ResetCycles + IdleCycles;

  typedef struct packed {
    logic                    rnd;    // checked against the shadow only
    logic                    we;
    logic [MemAddrWidth-1:0] addr;
    logic [MemDataWidth-1:0] wdata;
    logic [MemBeWidth-1:0]   be;
    logic [MemDataWidth-1:0] exp;    // hand-computed, reads only
  } row_t;

  logic                    clk;
  logic                    rst_n;
  logic                    req;
  mem_req_t                mem_req;
  logic                    gnt;
  logic                    rvalid;
  logic [MemDataWidth-1:0] rdata;

  row_t                    rows [NumRows];
  logic [MemDataWidth-1:0] shadow [NumWords];
  integer                  seed = 32'hadd64a40;
  int unsigned             errors = 0;
  int unsigned             checks = 0;
  int unsigned             gnt_cnt = 0;
  int unsigned             rsp_cnt = 0;

  tb_clk_gen #(
    .ResetCycles (ResetCycles)
  ) u_tb_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mem_subsys #(
    .NumWords (NumWords),
    .LfsrSeed (16'hace1)
  ) u_mem_subsys (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (req),
    .mem_req_i (mem_req),
    .gnt_o     (gnt),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata)
  );

  bind mem_subsys mem_subsys_sva u_mem_subsys_sva (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .gnt_i    (gnt_o),
    .rvalid_i (rvalid_o)
  );

  function automatic row_t make_row(
    input logic                    we,
    input logic [MemAddrWidth-1:0] addr,
    input logic [MemDataWidth-1:0] wdata,
    input logic [MemBeWidth-1:0]   be,
    input logic [MemDataWidth-1:0] exp
  );
    return '{rnd: 1'b0, we: we, addr: addr, wdata: wdata, be: be, exp: exp};
  endfunction

  // byte lanes with their enable set take the new data
  function automatic logic [MemDataWidth-1:0] merge_bytes(
    input logic [MemDataWidth-1:0] old_w,
    input logic [MemDataWidth-1:0] new_w,
    input logic [MemBeWidth-1:0]   be
  );
    logic [MemDataWidth-1:0] res;
    res = old_w;
    for (int b = 0; b < MemBeWidth; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic load_directed();
    rows[0]  = make_row(1'b1, 16'h0010, 32'hdeadbeef, 4'hf, '0);
    rows[1]  = make_row(1'b0, 16'h0010, '0, '0, 32'hdeadbeef);
    rows[2]  = make_row(1'b1, 16'h0020, 32'h11223344, 4'hf, '0);
    rows[3]  = make_row(1'b1, 16'h0020, 32'haabbccdd, 4'b0101, '0);  // lanes 0 and 2
    rows[4]  = make_row(1'b0, 16'h0020, '0, '0, 32'h11bb33dd);
    rows[5]  = make_row(1'b1, 16'h0030, 32'h00000000, 4'hf, '0);
    rows[6]  = make_row(1'b1, 16'h0030, 32'hcafef00d, 4'b1010, '0);  // lanes 1 and 3
    rows[7]  = make_row(1'b0, 16'h0030, '0, '0, 32'hca00f000);
    rows[8]  = make_row(1'b1, 16'h0011, 32'h12345678, 4'hf, '0);
    rows[9]  = make_row(1'b0, 16'h0010, '0, '0, 32'hdeadbeef);  // neighbour untouched
    rows[10] = make_row(1'b0, 16'h0011, '0, '0, 32'h12345678);
    rows[11] = make_row(1'b1, 16'h00ff, 32'h0badf00d, 4'hf, '0);
    rows[12] = make_row(1'b0, 16'h00ff, '0, '0, 32'h0badf00d);
    rows[13] = make_row(1'b0, 16'h0020, '0, '0, 32'h11bb33dd);
  endtask

  // random writes in a 16-word window, reads only of words already written
  task automatic build_tail();
    logic [NumWords-1:0] seen;
    logic [7:0]          wr_addrs [$];
    logic [31:0]         r;
    logic [7:0]          a;
    int                  pick;
    seen = '0;
    for (int i = NumDirected; i < NumRows; i++) begin
      r       = $random(seed);
      rows[i] = '0;
      rows[i].rnd = 1'b1;
      if (wr_addrs.size() == 0 || r[0]) begin
        a = 8'h40 + {4'h0, r[4:1]};
        rows[i].we    = 1'b1;
        rows[i].addr  = {8'h00, a};
        rows[i].wdata = $random(seed);
        rows[i].be    = seen[a] ? r[8:5] : 4'hf;  // first write fills the word
        seen[a] = 1'b1;
        wr_addrs.push_back(a);
      end else begin
        pick = int'(r[15:8]) % wr_addrs.size();
        rows[i].addr = {8'h00, wr_addrs[pick]};
      end
    end
  endtask

  task automatic check_idle(input int unsigned cycles);
    for (int unsigned c = 0; c < cycles; c++) begin
      @(negedge clk);
      checks++;
      assert (!gnt && !rvalid) else begin
        $display("mismatch at %0t: gnt %b rvalid %b while req is low after reset",
                 $time, gnt, rvalid);
        errors++;
      end
    end
  endtask

  task automatic run_row(input int idx);
    row_t                    row;
    logic [7:0]              widx;
    logic [MemDataWidth-1:0] exp;
    int unsigned             waited;
    int unsigned             lat;
    row     = rows[idx];
    widx    = row.addr[7:0];  // 256 words decode the low byte
    req     = 1'b1;
    mem_req = '{we: row.we, addr: row.addr, wdata: row.wdata, be: row.be};
    waited  = 0;
    @(negedge clk);
    while (!gnt && waited < GntTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (!gnt) begin
      $display("row %0d: request held high for %0d cycles and never granted", idx, GntTimeout);
      errors++;
      @(posedge clk);
      #10ns;
      req = 1'b0;
      return;
    end
    @(posedge clk);  // accepted at this edge
    #10ns;
    req     = 1'b0;
    mem_req = '0;
    if (row.we) begin
      shadow[widx] = merge_bytes(shadow[widx], row.wdata, row.be);
    end
    lat = 1;
    @(negedge clk);
    while (!rvalid && lat < RspTimeout) begin
      @(negedge clk);
      lat++;
    end
    if (!rvalid) begin
      $display("row %0d: no response within %0d cycles of the grant", idx, RspTimeout);
      errors++;
      return;
    end
    checks++;
    assert (lat >= 2 && lat <= 33) else begin
      $display("mismatch at %0t: row %0d answered %0d cycles after grant", $time, idx, lat);
      errors++;
    end
    if (!row.we) begin
      exp = shadow[widx];
      checks++;
      assert (rdata === exp) else begin
        $display("mismatch at %0t: row %0d addr %h read %h, shadow holds %h",
                 $time, idx, row.addr, rdata, exp);
        errors++;
      end
      if (!row.rnd) begin
        checks++;
        assert (rdata === row.exp) else begin
          $display("mismatch at %0t: row %0d addr %h read %h, table expects %h",
                   $time, idx, row.addr, rdata, row.exp);
          errors++;
        end
      end
    end
    $display("row %2d %s addr %h be %h data %h  grant wait %0d  latency %0d",
             idx, row.we ? "write" : "read ", row.addr, row.be,
             row.we ? row.wdata : rdata, waited, lat);
  endtask

  // grants against responses, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (gnt) begin
        gnt_cnt++;
      end
      if (rvalid) begin
        rsp_cnt++;
      end
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the rows did not complete", WatchdogCycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    req     = 1'b0;
    mem_req = '0;
    load_directed();
    build_tail();
    @(posedge rst_n);
    check_idle(IdleCycles);
    for (int i = 0; i < NumRows; i++) begin
      @(posedge clk);
      #10ns;
      run_row(i);
    end
    @(negedge clk);
    checks++;
    assert (gnt_cnt == rsp_cnt && gnt_cnt == NumRows) else begin
      $display("mismatch at %0t: %0d grants, %0d responses, %0d rows",
               $time, gnt_cnt, rsp_cnt, NumRows);
      errors++;
    end
    $display("rows %0d, checks %0d, errors %0d, grants %0d, responses %0d",
             NumRows, checks, errors, gnt_cnt, rsp_cnt);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_mem_subsys

`default_nettype wire

//--- verilog.f
rtl/mem_pkg.sv
rtl/latency_lfsr.sv
rtl/sram_1rw.sv
rtl/slow_mem_ctrl.sv
rtl/mem_subsys.sv
test/tb_clk_gen.sv
test/mem_subsys_sva.sv
test/tb_mem_subsys.sv

//--- Makefile
# Verilator build and run of the slow memory testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_mem_subsys
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TEST FAIL

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
